// File: common/monitor_pkg.sv
package monitor_pkg;

    // one retired instruction from the core
    typedef struct packed {
        logic [63:0] order;
        logic [31:0] inst;
        logic [4:0]  rs1_addr;
        logic [4:0]  rs2_addr;
        logic [4:0]  rd_addr;
        logic [31:0] rs1_rdata;
        logic [31:0] rs2_rdata;
        logic [31:0] rd_wdata;
        logic [31:0] pc_rdata;
        logic [31:0] pc_wdata;
        logic [31:0] mem_addr;
        logic [3:0]  mem_rmask;
        logic [3:0]  mem_wmask;
        logic [31:0] mem_rdata;
        logic [31:0] mem_wdata;
    } rvfi_commit_t;

    localparam int ERR_BITS = 6;

    typedef enum int unsigned {
        ERR_ORDER     = 0,  // order gap, first must be 0
        ERR_RMASK     = 1,
        ERR_WMASK     = 2,
        ERR_BOTH_MASK = 3,  // load and store in one commit
        ERR_X0_WRITE  = 4,
        ERR_PC_ALIGN  = 5
    } err_bit_e;

    typedef logic [ERR_BITS-1:0] errcode_t;

    typedef enum logic [31:0] {
        INST_SEG_START = 32'h0010_2013,  // slti x0, x0, 1
        INST_SEG_STOP  = 32'h0020_2013,  // slti x0, x0, 2
        INST_HALT_BEQ  = 32'h0000_0063,
        INST_HALT_JAL  = 32'h0000_006F,
        INST_HALT_SLTI = 32'hF000_2013
    } marker_inst_e;

    typedef struct packed {
        logic [31:0] seg_insts;
        logic [31:0] seg_cycles;
        logic        seg_done;
    } seg_result_t;

    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [7:0] REG_STATUS     = 8'h00;
    localparam logic [7:0] REG_ERRCODE    = 8'h04;
    localparam logic [7:0] REG_SEG_INSTS  = 8'h08;
    localparam logic [7:0] REG_SEG_CYCLES = 8'h0C;
    localparam logic [7:0] REG_COMMITS    = 8'h10;
    localparam logic [7:0] REG_CONTROL    = 8'h14;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: source/commit_checker.sv
`timescale 1ns/10ps

module commit_checker (
    input  logic                      itf,
    input  logic                      reset,
    input  logic                      commit_valid,
    input  monitor_pkg::rvfi_commit_t commit,
    input  logic                      clear_errors,
    output monitor_pkg::errcode_t     errcode,
    output logic                      halt,
    output logic [31:0]               commit_total
);
    import monitor_pkg::*;

    logic [63:0] next_order;   // expected order of the next commit
    errcode_t    violations;
    errcode_t    new_errors;
    logic        halt_hit;

    // byte, aligned half or full word
    function automatic logic mask_legal(input logic [3:0] mask);
        logic ok;
        case (mask)
            4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000: ok = 1'b1;
            4'b0011, 4'b1100, 4'b1111: ok = 1'b1;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    always_comb begin
        violations                = '0;
        violations[ERR_ORDER]     = commit.order != next_order;
        violations[ERR_RMASK]     = !mask_legal(commit.mem_rmask);
        violations[ERR_WMASK]     = !mask_legal(commit.mem_wmask);
        violations[ERR_BOTH_MASK] = (|commit.mem_rmask) && (|commit.mem_wmask);
        violations[ERR_X0_WRITE]  = (commit.rd_addr == 5'd0) && (|commit.rd_wdata);
        violations[ERR_PC_ALIGN]  = commit.pc_wdata[0];
    end

    assign new_errors = commit_valid ? violations : '0;

    // self-loop or one of the halt encodings
    assign halt_hit = (commit.pc_rdata == commit.pc_wdata)
                   || (commit.inst inside {INST_HALT_BEQ, INST_HALT_JAL, INST_HALT_SLTI});

    always_ff @(posedge itf) begin
        if (reset) begin
            next_order   <= '0;
            errcode      <= '0;
            halt         <= 1'b0;
            commit_total <= '0;
        end else begin
            // a violation in the clear cycle still lands
            errcode <= (clear_errors ? '0 : errcode) | new_errors;
            if (commit_valid) begin
                next_order   <= commit.order + 64'd1;  // resync after a gap
                commit_total <= commit_total + 32'd1;
                if (halt_hit) begin
                    halt <= 1'b1;  // sticky, survives clear
                end
            end
        end
    end

endmodule

// File: source/segment_counter.sv
`timescale 1ns/10ps

module segment_counter (
    input  logic                      itf,
    input  logic                      reset,
    input  logic                      commit_valid,
    input  monitor_pkg::rvfi_commit_t commit,
    output monitor_pkg::seg_result_t  seg_result
);
    import monitor_pkg::*;

    logic [31:0] inst_count;
    logic [31:0] cycle_count;
    logic        is_start;
    logic        is_stop;

    assign is_start = commit_valid && (commit.inst == INST_SEG_START);
    assign is_stop  = commit_valid && (commit.inst == INST_SEG_STOP);

    always_ff @(posedge itf) begin
        if (reset) begin
            inst_count  <= '0;
            cycle_count <= '0;
        end else if (is_start) begin
            inst_count  <= '0;  // start commit not counted
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
            if (commit_valid) begin
                inst_count <= inst_count + 32'd1;
            end
        end
    end

    // stop commit and its cycle are part of the segment
    always_ff @(posedge itf) begin
        if (reset) begin
            seg_result <= '0;
        end else if (is_stop) begin
            seg_result.seg_insts  <= inst_count + 32'd1;
            seg_result.seg_cycles <= cycle_count + 32'd1;
            seg_result.seg_done   <= 1'b1;
        end
    end

endmodule

// File: source/monitor_regs.sv
`timescale 1ns/10ps

module monitor_regs (
    input  logic                     itf,
    input  logic                     reset,
    input  monitor_pkg::axil_req_t   axil_req,
    output monitor_pkg::axil_rsp_t   axil_rsp,
    input  monitor_pkg::errcode_t    errcode,
    input  logic                     halt,
    input  logic [31:0]              commit_total,
    input  monitor_pkg::seg_result_t seg_result,
    output logic                     clear_errors
);
    import monitor_pkg::*;

    logic        wr_ready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        rd_ready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        wr_fire;
    logic        rd_fire;
    logic        ctrl_hit;
    logic [31:0] rd_data;
    logic [1:0]  rd_resp;

    assign wr_fire  = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire  = rd_ready && axil_req.arvalid;
    assign ctrl_hit = axil_req.awaddr == REG_CONTROL;  // only writable register

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            REG_STATUS:     rd_data = {29'd0, |errcode, seg_result.seg_done, halt};
            REG_ERRCODE:    rd_data = 32'(errcode);
            REG_SEG_INSTS:  rd_data = seg_result.seg_insts;
            REG_SEG_CYCLES: rd_data = seg_result.seg_cycles;
            REG_COMMITS:    rd_data = commit_total;
            REG_CONTROL:    rd_data = '0;  // clear is self-resetting
            default:        rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            wr_ready     <= 1'b0;
            bvalid       <= 1'b0;
            rd_ready     <= 1'b0;
            rvalid       <= 1'b0;
            clear_errors <= 1'b0;
        end else begin
            // one-cycle ready pulses, none while a response is pending
            wr_ready     <= axil_req.awvalid && axil_req.wvalid && !bvalid && !wr_ready;
            rd_ready     <= axil_req.arvalid && !rvalid && !rd_ready;
            clear_errors <= wr_fire && ctrl_hit && axil_req.wstrb[0] && axil_req.wdata[0];
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (wr_fire) begin
            bresp <= ctrl_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_data;  // snapshot at accept
            rresp <= rd_resp;
        end
    end

    assign axil_rsp = '{awready: wr_ready, wready: wr_ready, bvalid: bvalid, bresp: bresp,
                        arready: rd_ready, rvalid: rvalid, rdata: rdata, rresp: rresp};

endmodule

// File: source/monitor_top.sv
`timescale 1ns/10ps

module monitor_top (
    input  logic                      itf,
    input  logic                      reset,
    input  logic                      commit_valid,
    input  monitor_pkg::rvfi_commit_t commit,
    input  monitor_pkg::axil_req_t    axil_req,
    output monitor_pkg::axil_rsp_t    axil_rsp,
    output logic                      halt,
    output logic                      error
);
    import monitor_pkg::*;

    errcode_t    errcode;
    logic        clear_errors;
    logic [31:0] commit_total;
    seg_result_t seg_result;

    assign error = |errcode;

    commit_checker u_checker (
        .itf          (itf),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit       (commit),
        .clear_errors (clear_errors),
        .errcode      (errcode),
        .halt         (halt),
        .commit_total (commit_total)
    );

    segment_counter u_segment (
        .itf          (itf),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit       (commit),
        .seg_result   (seg_result)
    );

    monitor_regs u_regs (
        .itf          (itf),
        .reset        (reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .errcode      (errcode),
        .halt         (halt),
        .commit_total (commit_total),
        .seg_result   (seg_result),
        .clear_errors (clear_errors)
    );

endmodule

// File: tests/monitor_assertions.sv
`timescale 1ns/10ps

module monitor_assertions (
    input logic                   itf,
    input logic                   reset,
    input monitor_pkg::axil_req_t axil_req,
    input monitor_pkg::axil_rsp_t axil_rsp
);
    logic b_hold_fail   = 1'b0;
    logic r_hold_fail   = 1'b0;
    logic r_stable_fail = 1'b0;
    logic reset_fail    = 1'b0;
    logic failed;

    assign failed = b_hold_fail | r_hold_fail | r_stable_fail | reset_fail;

    b_hold: assert property (@(posedge itf) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        b_hold_fail = 1'b1;
        $error("bvalid dropped before bready");
    end

    r_hold: assert property (@(posedge itf) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
        r_hold_fail = 1'b1;
        $error("rvalid dropped before rready");
    end

    r_stable: assert property (@(posedge itf) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rdata))
    else begin
        r_stable_fail = 1'b1;
        $error("rdata changed while the read was stalled");
    end

    // responses idle one cycle into reset and after
    reset_idle: assert property (@(posedge itf)
        reset |=> !axil_rsp.bvalid && !axil_rsp.rvalid)
    else begin
        reset_fail = 1'b1;
        $error("response valid while in reset");
    end

endmodule

bind monitor_regs monitor_assertions u_assertions (
    .itf      (itf),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
);

// File: tests/monitor_tb.sv
`timescale 1ns/10ps

module monitor_tb;
    import monitor_pkg::*;

    localparam string CASE_FILE = "tests/monitor_cases.txt";

    logic         itf;
    logic         reset;
    logic         commit_valid;
    rvfi_commit_t commit;
    axil_req_t    axil_req;
    axil_rsp_t    axil_rsp;
    logic         halt;
    logic         error;

    byte         kinds[$];
    string       names[$];
    logic [63:0] vals[$];     // nine fields per case line
    logic [63:0] next_order;  // order used by stall commits
    int          cycles;
    int          cycle_limit;

    monitor_top UUT (
        .itf          (itf),
        .reset        (reset),
        .commit_valid (commit_valid),
        .commit       (commit),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .halt         (halt),
        .error        (error)
    );

    always #50 itf = ~itf;

    always @(posedge itf) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            abort_run("timeout: the cases did not finish within the cycle limit");
        end else if (UUT.u_regs.u_assertions.failed) begin
            abort_run("an AXI protocol assertion failed");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s resp: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_errcode(input string name, input errcode_t exp, input errcode_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s errcode: expected %b, actual %b",
                                name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          ch;
        int          fields;
        int          busy;
        int          accesses;
        string       tok;
        string       name;
        logic [63:0] v;
        busy     = 4;  // initial reset
        accesses = 0;
        fd       = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the case file");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                do begin
                    ch = $fgetc(fd);
                end while (ch != "\n" && ch != -1);
            end else begin
                void'($fscanf(fd, "%s", name));
                case (tok)
                    "C": fields = 9;
                    "I": fields = 1;
                    "R": fields = 4;
                    "W": fields = 3;
                    "X": fields = 0;
                    default: abort_run({"unknown line kind in the case file: ", tok});
                endcase
                kinds.push_back(tok[0]);
                names.push_back(name);
                for (int k = 0; k < 9; k++) begin
                    v = '0;
                    if (k < fields) begin
                        void'($fscanf(fd, "%h", v));
                    end
                    vals.push_back(v);
                end
                case (tok)
                    "C": busy += 1;
                    "I": busy += int'(vals[$-8]);
                    "W": accesses += 1;
                    "X": busy += 5;
                    default: begin
                        accesses += 1;
                        busy     += int'(vals[$-5]);  // stall commits
                    end
                endcase
            end
        end
        $fclose(fd);
        cycle_limit = 2 * busy + 20 * accesses;
    endtask

    function automatic rvfi_commit_t make_commit(input int base);
        rvfi_commit_t c;
        c           = '0;
        c.order     = vals[base];
        c.inst      = vals[base+1][31:0];
        c.pc_rdata  = vals[base+2][31:0];
        c.pc_wdata  = vals[base+3][31:0];
        c.rd_addr   = vals[base+4][4:0];
        c.rd_wdata  = vals[base+5][31:0];
        c.mem_rmask = vals[base+6][3:0];
        c.mem_wmask = vals[base+7][3:0];
        c.mem_addr  = vals[base+8][31:0];
        return c;
    endfunction

    function automatic rvfi_commit_t filler_commit();
        rvfi_commit_t c;
        c          = '0;
        c.order    = next_order;
        c.inst     = 32'h0000_0013;  // nop
        c.pc_rdata = 32'h0000_4000;
        c.pc_wdata = 32'h0000_4004;
        return c;
    endfunction

    task automatic send_commit(input rvfi_commit_t c);
        @(posedge itf);
        commit_valid <= 1'b1;
        commit       <= c;
        next_order   = c.order + 64'd1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge itf);
            commit_valid <= 1'b0;
        end
    endtask

    task automatic pulse_reset();
        @(posedge itf);
        commit_valid <= 1'b0;
        reset        <= 1'b1;
        repeat (4) @(posedge itf);
        reset <= 1'b0;
    endtask

    task automatic axi_read(input string name, input logic [7:0] addr,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp,
                            input int stall);
        @(posedge itf);
        commit_valid     <= 1'b0;
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= (stall == 0);
        do begin
            @(posedge itf);
        end while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        repeat (stall) send_commit(filler_commit());  // counted while rready is low
        if (stall > 0) begin
            @(posedge itf);
            commit_valid    <= 1'b0;
            axil_req.rready <= 1'b1;
        end
        do begin
            @(posedge itf);
        end while (!(axil_rsp.rvalid && axil_req.rready));
        axil_req.rready <= 1'b0;
        check_resp(name, exp_resp, axil_rsp.rresp);
        if (addr == REG_ERRCODE) begin
            check_errcode(name, exp_data[ERR_BITS-1:0], axil_rsp.rdata[ERR_BITS-1:0]);
        end
        check_data(name, exp_data, axil_rsp.rdata);
        if (addr == REG_STATUS) begin
            check_flag({name, " halt port"}, exp_data[0], halt);
            check_flag({name, " error port"}, exp_data[2], error);
        end
    endtask

    task automatic axi_write(input string name, input logic [7:0] addr,
                             input logic [31:0] data, input logic [1:0] exp_resp);
        @(posedge itf);
        commit_valid     <= 1'b0;
        axil_req.awvalid <= 1'b1;
        axil_req.wvalid  <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hF;
        do begin
            @(posedge itf);
        end while (!axil_rsp.awready);
        check_flag({name, " wready"}, 1'b1, axil_rsp.wready);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        repeat (2) @(posedge itf);  // response held back
        axil_req.bready <= 1'b1;
        do begin
            @(posedge itf);
        end while (!(axil_rsp.bvalid && axil_req.bready));
        axil_req.bready <= 1'b0;
        check_resp(name, exp_resp, axil_rsp.bresp);
    endtask

    task automatic run_case(input int i);
        int base;
        base = 9 * i;
        case (kinds[i])
            "C": send_commit(make_commit(base));
            "I": idle(int'(vals[base]));
            "R": axi_read(names[i], vals[base][7:0], vals[base+1][31:0], vals[base+2][1:0],
                          int'(vals[base+3]));
            "W": axi_write(names[i], vals[base][7:0], vals[base+1][31:0], vals[base+2][1:0]);
            default: pulse_reset();
        endcase
    endtask

    initial begin
        itf          = 1'b0;
        reset        = 1'b1;
        commit_valid = 1'b0;
        commit       = '0;
        axil_req     = '0;
        next_order   = '0;
        load_cases();
        repeat (4) @(posedge itf);
        reset <= 1'b0;
        for (int i = 0; i < kinds.size(); i++) begin
            run_case(i);
        end
        idle(2);
        if (!UUT.u_regs.u_assertions.failed) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("an AXI protocol assertion failed");
        end
    end

endmodule

// File: tests/monitor_cases.txt
# C name order inst pc_rdata pc_wdata rd_addr rd_wdata rmask wmask mem_addr | I name cycles
# R name offset data resp stall | W name offset data resp | X name (reset), values in hex
C clean_addi 0 00a00093 1000 1004 01 a 0 0 0
C clean_lw 1 0000a103 1004 1008 02 12345678 f 0 100
R clean_errcode 04 0 0 0
R clean_commits 10 2 0 0
C bad_order 7 00000013 1008 100c 00 0 0 0 0
R order_status 00 4 0 0
R order_errcode 04 1 0 0
W order_clear 14 1 0
C bad_rmask 8 0000a103 100c 1010 02 0 5 0 100
R rmask_errcode 04 2 0 0
W rmask_clear 14 1 0
C bad_wmask 9 00208023 1010 1014 00 0 0 6 104
R wmask_errcode 04 4 0 0
W wmask_clear 14 1 0
C bad_both a 00000013 1014 1018 00 0 1 2 108
R both_errcode 04 8 0 0
W both_clear 14 1 0
C bad_x0 b 00500013 1018 101c 00 5 0 0 0
R x0_errcode 04 10 0 0
W x0_clear 14 1 0
C bad_pc c 00000067 101c 1001 00 0 0 0 0
R pc_errcode 04 20 0 0
W pc_clear 14 1 0
C seg_start d 00102013 1020 1024 00 0 0 0 0
C seg_a e 00000013 1024 1028 00 0 0 0 0
C seg_b f 00000013 1028 102c 00 0 0 0 0
I seg_gap 4
C seg_stop 10 00202013 102c 1030 00 0 0 0 0
R seg_insts 08 3 0 0
R seg_cycles 0c 7 0 0
R stall_commits 10 c 0 5
R after_stall 10 11 0 0
R unmapped 40 0 2 0
W ro_write 04 1 2
C self_loop 16 00108063 2000 2000 00 0 0 0 0
R loop_status 00 3 0 0
W loop_clear 14 1 0
R loop_kept 00 3 0 0
X fresh_reset
C halt_jal 0 0000006f 3000 3004 00 0 0 0 0
R jal_status 00 1 0 0

// File: compile.f
common/monitor_pkg.sv
source/commit_checker.sv
source/segment_counter.sv
source/monitor_regs.sv
source/monitor_top.sv
tests/monitor_assertions.sv
tests/monitor_tb.sv

// File: Bender.yml
package:
  name: commit_monitor

sources:
  - common/monitor_pkg.sv
  - source/commit_checker.sv
  - source/segment_counter.sv
  - source/monitor_regs.sv
  - source/monitor_top.sv
  - target: test
    files:
      - tests/monitor_assertions.sv
      - tests/monitor_tb.sv
